/* common/cosPkg.sv */
// Clock and baud constants, data widths, bus structs and FSM states for the UART control path
package cosPkg;

  // **************************************************
  // Clock and serial timing
  localparam int ClockHz        = 125_000_000;
  localparam int UartBaud       = 7_812_500;
  localparam int CyclesPerBit   = ClockHz / UartBaud;
  localparam int HalfBit        = CyclesPerBit / 2;
  // One bit time of idle line plus margin for the host
  localparam int TopResetCycles = CyclesPerBit + 50;

  localparam int TickCountWidth  = $clog2(CyclesPerBit);
  localparam int ResetCountWidth = $clog2(TopResetCycles + 1);

  // **************************************************
  // Plain vector types
  typedef logic [7:0]                 byteT;
  typedef logic [7:0]                 ledT;
  typedef logic [7:0]                 gpioT;
  typedef logic [3:0]                 errorCountT;
  typedef logic [TickCountWidth-1:0]  tickCountT;
  typedef logic [ResetCountWidth-1:0] resetCountT;

  // Command targets
  localparam byteT TargetLed   = 8'h00;
  localparam byteT TargetGpio  = 8'h01;
  localparam byteT TargetReset = 8'hFF;

  // Register addresses inside each target
  localparam byteT AddrLed          = 8'h00;
  localparam byteT AddrGpioOut      = 8'h00;
  localparam byteT AddrGpioTristate = 8'h01;

  localparam errorCountT ErrorCountMax = 4'd15;

  // **************************************************
  // Bus structs
  typedef struct packed {
    byteT data;
    logic framingError;
  } rxByteT;

  typedef struct packed {
    byteT target;
    byteT addr;
    byteT data;
  } commandT;

  typedef struct packed {
    errorCountT framingErrors;
    errorCountT commandErrors;
  } cosStatusT;

  // **************************************************
  // State machines
  typedef enum logic [2:0] {
    RxIdle, RxStart, RxData, RxStop, RxDeliver
  } rxStateE;

  typedef enum logic [1:0] {
    FrTarget, FrAddr, FrData, FrWaitAckLow
  } framerStateE;

endpackage

/* logic/resetStretch.sv */
// Reset stretcher merging the board reset with reset commands from the host
`timescale 1ns/1ps

module resetStretch (
  input  logic clock,
  input  logic rstN,
  input  logic resetRequest,
  output logic coreRstN
);

  cosPkg::resetCountT holdCount;

  // Either source reloads the hold count
  // Release happens on the edge where the count runs out
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      holdCount <= cosPkg::resetCountT'(cosPkg::TopResetCycles);
      coreRstN  <= 1'b0;
    end else if (resetRequest) begin
      holdCount <= cosPkg::resetCountT'(cosPkg::TopResetCycles);
      coreRstN  <= 1'b0;
    end else begin
      if (holdCount != '0) begin
        holdCount <= holdCount - 1'b1;
      end
      coreRstN <= (holdCount <= cosPkg::resetCountT'(1));
    end
  end

endmodule

/* uart/uartByteRx.sv */
// UART 8N1 receiver with input synchronizer, mid-bit sampling and four-phase byte delivery
`timescale 1ns/1ps

module uartByteRx (
  input  logic           clock,
  input  logic           rstN,
  input  logic           uartRx,
  output cosPkg::rxByteT rxByte,
  output logic           byteReq,
  input  logic           byteAck
);

  logic              rxMeta;
  logic              rxSync;
  cosPkg::rxStateE   state;
  cosPkg::tickCountT tickCount;
  logic [2:0]        bitIndex;
  logic              pending;
  logic              sampleTick;

  // Line idles high
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= uartRx;
      rxSync <= rxMeta;
    end
  end

  assign sampleTick = (tickCount == '0);

  // **************************************************
  // Bit timing FSM
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state     <= cosPkg::RxIdle;
      tickCount <= '0;
      bitIndex  <= '0;
      pending   <= 1'b0;
    end else begin
      case (state)
        cosPkg::RxIdle: begin
          if (!rxSync) begin
            tickCount <= cosPkg::tickCountT'(cosPkg::HalfBit - 1);
            state     <= cosPkg::RxStart;
          end
        end
        cosPkg::RxStart: begin
          if (!sampleTick) begin
            tickCount <= tickCount - 1'b1;
          end else if (!rxSync) begin
            // Start bit confirmed at its middle
            tickCount <= cosPkg::tickCountT'(cosPkg::CyclesPerBit - 1);
            bitIndex  <= '0;
            state     <= cosPkg::RxData;
          end else begin
            state <= cosPkg::RxIdle;
          end
        end
        cosPkg::RxData: begin
          if (!sampleTick) begin
            tickCount <= tickCount - 1'b1;
          end else begin
            tickCount <= cosPkg::tickCountT'(cosPkg::CyclesPerBit - 1);
            bitIndex  <= bitIndex + 1'b1;
            if (bitIndex == 3'd7) begin
              state <= cosPkg::RxStop;
            end
          end
        end
        cosPkg::RxStop: begin
          if (!sampleTick) begin
            tickCount <= tickCount - 1'b1;
          end else begin
            // Count out the rest of the stop bit while delivering
            tickCount <= cosPkg::tickCountT'(cosPkg::HalfBit - 2);
            pending   <= 1'b1;
            state     <= cosPkg::RxDeliver;
          end
        end
        default: begin
          if (!sampleTick) begin
            tickCount <= tickCount - 1'b1;
          end
          if (pending && !byteAck) begin
            pending <= 1'b0;
          end
          if (sampleTick && !pending && !byteReq) begin
            state <= cosPkg::RxIdle;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (state == cosPkg::RxData && sampleTick) begin
      rxByte.data <= {rxSync, rxByte.data[7:1]};
    end
    if (state == cosPkg::RxStop && sampleTick) begin
      rxByte.framingError <= !rxSync;
    end
  end

  // **************************************************
  // Four-phase request side
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      byteReq <= 1'b0;
    end else if (pending && !byteAck) begin
      byteReq <= 1'b1;
    end else if (byteReq && byteAck) begin
      byteReq <= 1'b0;
    end
  end

  reqAfterAckLow: assert property (@(posedge clock) disable iff (!rstN)
    $rose(byteReq) |-> !byteAck);

  rxByteHeld: assert property (@(posedge clock) disable iff (!rstN)
    byteReq && $past(byteReq) |-> $stable(rxByte));

  // Handshake must finish within one byte time
  noOverrun: assert property (@(posedge clock) disable iff (!rstN)
    (state == cosPkg::RxStop && sampleTick) |-> !byteReq);

endmodule

/* csr/commandFramer.sv */
// Command framer collecting target, address and data bytes into write commands
`timescale 1ns/1ps

module commandFramer (
  input  logic               clock,
  input  logic               rstN,
  input  cosPkg::rxByteT     rxByte,
  input  logic               byteReq,
  output logic               byteAck,
  output cosPkg::commandT    cmd,
  output logic               cmdValid,
  output cosPkg::errorCountT framingErrors
);

  cosPkg::framerStateE state;
  cosPkg::framerStateE nextField;
  logic                cmdFull;
  logic                takeByte;

  // Ack is low in every field state
  assign takeByte = byteReq && (state != cosPkg::FrWaitAckLow);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state         <= cosPkg::FrTarget;
      nextField     <= cosPkg::FrTarget;
      byteAck       <= 1'b0;
      cmdFull       <= 1'b0;
      cmdValid      <= 1'b0;
      framingErrors <= '0;
    end else begin
      cmdValid <= 1'b0;
      if (takeByte) begin
        byteAck <= 1'b1;
        state   <= cosPkg::FrWaitAckLow;
        if (rxByte.framingError) begin
          // Drop any partial command
          nextField <= cosPkg::FrTarget;
          if (framingErrors != cosPkg::ErrorCountMax) begin
            framingErrors <= framingErrors + 1'b1;
          end
        end else begin
          case (state)
            cosPkg::FrTarget: nextField <= cosPkg::FrAddr;
            cosPkg::FrAddr:   nextField <= cosPkg::FrData;
            default: begin
              nextField <= cosPkg::FrTarget;
              cmdFull   <= 1'b1;
            end
          endcase
        end
      end else if (state == cosPkg::FrWaitAckLow) begin
        if (cmdFull) begin
          cmdValid <= 1'b1;
          cmdFull  <= 1'b0;
        end
        if (!byteReq) begin
          byteAck <= 1'b0;
          state   <= nextField;
        end
      end
    end
  end

  // Command fields
  always_ff @(posedge clock) begin
    if (takeByte && !rxByte.framingError) begin
      case (state)
        cosPkg::FrTarget: cmd.target <= rxByte.data;
        cosPkg::FrAddr:   cmd.addr   <= rxByte.data;
        default:          cmd.data   <= rxByte.data;
      endcase
    end
  end

endmodule

/* csr/ioRegisterBank.sv */
// LED and GPIO register bank with command decode, error count and reset request
`timescale 1ns/1ps

module ioRegisterBank (
  input  logic               clock,
  input  logic               rstN,
  input  cosPkg::commandT    cmd,
  input  logic               cmdValid,
  output cosPkg::ledT        ledOut,
  output cosPkg::gpioT       gpioOut,
  output cosPkg::gpioT       gpioTristate,
  output cosPkg::errorCountT commandErrors,
  output logic               resetRequest
);

  logic cmdBad;

  // **************************************************
  // Target and address decode
  always_comb begin
    cmdBad = 1'b0;
    case (cmd.target)
      cosPkg::TargetLed: begin
        cmdBad = (cmd.addr != cosPkg::AddrLed);
      end
      cosPkg::TargetGpio: begin
        cmdBad = (cmd.addr != cosPkg::AddrGpioOut) &&
                 (cmd.addr != cosPkg::AddrGpioTristate);
      end
      // Reset ignores address and data
      cosPkg::TargetReset: begin
        cmdBad = 1'b0;
      end
      default: begin
        cmdBad = 1'b1;
      end
    endcase
  end

  // **************************************************
  // Registers
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      ledOut        <= '0;
      gpioOut       <= '0;
      gpioTristate  <= '1;
      commandErrors <= '0;
      resetRequest  <= 1'b0;
    end else begin
      resetRequest <= 1'b0;
      if (cmdValid) begin
        if (cmdBad) begin
          if (commandErrors != cosPkg::ErrorCountMax) begin
            commandErrors <= commandErrors + 1'b1;
          end
        end else begin
          case (cmd.target)
            cosPkg::TargetLed: begin
              ledOut <= cmd.data;
            end
            cosPkg::TargetGpio: begin
              if (cmd.addr == cosPkg::AddrGpioOut) begin
                gpioOut <= cmd.data;
              end else begin
                gpioTristate <= cmd.data;
              end
            end
            default: begin
              resetRequest <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  // A strobe held for two cycles would apply one command twice
  cmdValidPulse: assert property (@(posedge clock) disable iff (!rstN)
    cmdValid |=> !cmdValid);

endmodule

/* logic/cosTop.sv */
// Top level of the UART control path with reset stretcher, receiver, framer and register bank
`timescale 1ns/1ps

module cosTop (
  input  logic              clock,
  input  logic              rstN,
  input  logic              uartRx,
  output cosPkg::ledT       ledOut,
  output cosPkg::gpioT      gpioOut,
  output cosPkg::gpioT      gpioTristate,
  output cosPkg::cosStatusT status
);

  logic               coreRstN;
  logic               resetRequest;
  logic               byteReq;
  logic               byteAck;
  logic               cmdValid;
  cosPkg::rxByteT     rxByte;
  cosPkg::commandT    cmd;
  cosPkg::errorCountT framingErrors;
  cosPkg::errorCountT commandErrors;

  // **************************************************
  // Reset
  resetStretch uRESET (
    .clock        (clock),
    .rstN         (rstN),
    .resetRequest (resetRequest),
    .coreRstN     (coreRstN)
  );

  // **************************************************
  // Serial receive and command path
  uartByteRx uUART_RX (
    .clock   (clock),
    .rstN    (coreRstN),
    .uartRx  (uartRx),
    .rxByte  (rxByte),
    .byteReq (byteReq),
    .byteAck (byteAck)
  );

  commandFramer uFRAMER (
    .clock         (clock),
    .rstN          (coreRstN),
    .rxByte        (rxByte),
    .byteReq       (byteReq),
    .byteAck       (byteAck),
    .cmd           (cmd),
    .cmdValid      (cmdValid),
    .framingErrors (framingErrors)
  );

  ioRegisterBank uREGS (
    .clock         (clock),
    .rstN          (coreRstN),
    .cmd           (cmd),
    .cmdValid      (cmdValid),
    .ledOut        (ledOut),
    .gpioOut       (gpioOut),
    .gpioTristate  (gpioTristate),
    .commandErrors (commandErrors),
    .resetRequest  (resetRequest)
  );

  assign status.framingErrors = framingErrors;
  assign status.commandErrors = commandErrors;

endmodule

/* test/cosTopTb.sv */
// Trace-driven testbench for the UART control path with serializer, compare tasks and timeout
`timescale 1ns/1ps

module cosTopTb;

  localparam int BitCycles   = cosPkg::CyclesPerBit;
  localparam int ResetWait   = cosPkg::TopResetCycles + 2 * cosPkg::CyclesPerBit;
  // Worst case per trace line
  localparam int LineBudget  = 30 * cosPkg::CyclesPerBit + 45 + cosPkg::TopResetCycles;

  logic              clock;
  logic              rstN;
  logic              uartRx;
  cosPkg::ledT       ledOut;
  cosPkg::gpioT      gpioOut;
  cosPkg::gpioT      gpioTristate;
  cosPkg::cosStatusT status;

  logic [31:0] lcgState;
  int          cycleCount;
  int          cycleLimit;
  int          checkCount;

  cosTop DUT (
    .clock        (clock),
    .rstN         (rstN),
    .uartRx       (uartRx),
    .ledOut       (ledOut),
    .gpioOut      (gpioOut),
    .gpioTristate (gpioTristate),
    .status       (status)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // **************************************************
  // Helpers
  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped");
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] seed);
    return seed * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic driveBit(input logic level);
    @(posedge clock);
    #1 uartRx = level;
    repeat (BitCycles - 1) @(posedge clock);
  endtask

  // 8N1 frame, LSB first, then a random idle gap
  task automatic sendByte(input cosPkg::byteT value, input logic stopLevel);
    int gap;
    driveBit(1'b0);
    for (int i = 0; i < 8; i++) begin
      driveBit(value[i]);
    end
    driveBit(stopLevel);
    @(posedge clock);
    #1 uartRx = 1'b1;
    lcgState = lcgNext(lcgState);
    gap = lcgState[19:16];
    repeat (gap) @(posedge clock);
  endtask

  task automatic checkLed(input cosPkg::ledT expected);
    checkCount++;
    if (ledOut !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t: ledOut is %h, expected %h",
                                $time, ledOut, expected));
    end
  endtask

  task automatic checkGpio(input cosPkg::gpioT expOut, input cosPkg::gpioT expTri);
    checkCount++;
    if (gpioOut !== expOut || gpioTristate !== expTri) begin
      stopWithFailure($sformatf("mismatch at %0t: gpio out/tristate is %h/%h, expected %h/%h",
                                $time, gpioOut, gpioTristate, expOut, expTri));
    end
  endtask

  task automatic checkStatus(input cosPkg::cosStatusT expected);
    checkCount++;
    if (status !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t: framing/command errors are %h/%h, expected %h/%h",
                                $time, status.framingErrors, status.commandErrors,
                                expected.framingErrors, expected.commandErrors));
    end
  endtask

  // **************************************************
  // Timeout
  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      stopWithFailure($sformatf("timeout after %0d cycles, the trace did not finish", cycleCount));
    end
  end

  // **************************************************
  // Trace player
  initial begin
    int                 fd;
    int                 rc;
    int                 lineCount;
    logic [7:0]         op;
    logic [8*128-1:0]   lineBuf;
    cosPkg::byteT       target;
    cosPkg::byteT       addr;
    cosPkg::byteT       data;
    logic               stopLevel;
    cosPkg::ledT        expLed;
    cosPkg::gpioT       expOut;
    cosPkg::gpioT       expTri;
    cosPkg::errorCountT expFraming;
    cosPkg::errorCountT expCommand;
    bit                 done;

    rstN       = 1'b0;
    uartRx     = 1'b1;
    lcgState   = 32'h1615_c706;
    cycleCount = 0;
    checkCount = 0;
    cycleLimit = 0;

    fd = $fopen("test/cosTrace.txt", "r");
    if (fd == 0) begin
      stopWithFailure("cannot open the trace file test/cosTrace.txt");
    end
    lineCount = 0;
    while (!$feof(fd)) begin
      rc = $fgets(lineBuf, fd);
      if (rc > 0) begin
        lineCount++;
      end
    end
    $fclose(fd);
    cycleLimit = lineCount * LineBudget;
    fd = $fopen("test/cosTrace.txt", "r");

    repeat (8) @(posedge clock);
    #1 rstN = 1'b1;
    repeat (ResetWait) @(posedge clock);

    done = 1'b0;
    while (!done) begin
      rc = $fscanf(fd, " %c", op);
      if (rc != 1) begin
        done = 1'b1;
      end else begin
        case (op)
          "#": rc = $fgets(lineBuf, fd);
          "C": begin
            rc = $fscanf(fd, "%h %h %h", target, addr, data);
            if (rc != 3) begin
              stopWithFailure("malformed command line in the trace file");
            end
            sendByte(target, 1'b1);
            sendByte(addr, 1'b1);
            sendByte(data, 1'b1);
          end
          "B": begin
            rc = $fscanf(fd, "%h %h", data, stopLevel);
            if (rc != 2) begin
              stopWithFailure("malformed byte line in the trace file");
            end
            sendByte(data, stopLevel);
          end
          "R": repeat (ResetWait) @(posedge clock);
          "E": begin
            rc = $fscanf(fd, "%h %h %h %h %h", expLed, expOut, expTri, expFraming, expCommand);
            if (rc != 5) begin
              stopWithFailure("malformed expect line in the trace file");
            end
            // Outputs settle well inside one bit time
            repeat (BitCycles) @(posedge clock);
            @(negedge clock);
            checkLed(expLed);
            checkGpio(expOut, expTri);
            checkStatus({expFraming, expCommand});
          end
          default: stopWithFailure($sformatf("unknown operation %c in the trace file", op));
        endcase
      end
    end
    $fclose(fd);

    if (checkCount == 0) begin
      stopWithFailure("the trace file holds no checks");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* test/cosTrace.txt */
# C target addr data | B byte stopBit | R wait out the stretched reset
# E led gpioOut gpioTristate framingErrors commandErrors, all values hex
E 00 00 ff 0 0
C 00 00 a5
E a5 00 ff 0 0
C 00 00 3c
E 3c 00 ff 0 0
C 01 00 5a
E 3c 5a ff 0 0
C 01 01 0f
C 01 00 c3
E 3c c3 0f 0 0
C 02 00 11
C 00 01 22
C 01 02 33
E 3c c3 0f 0 3
C 7e 00 44
C 10 01 45
C 00 02 46
C 01 80 47
C 03 00 48
C 00 ff 49
C 01 03 4a
C 40 00 4b
C 00 10 4c
C fe 01 4d
C 01 7f 4e
C 08 00 4f
E 3c c3 0f 0 f
C 01 05 55
E 3c c3 0f 0 f
B 01 1
B 00 1
B 99 0
E 3c c3 0f 1 f
C 01 00 66
E 3c 66 0f 1 f
C ff 00 00
R
E 00 00 ff 0 0
C 00 00 81
E 81 00 ff 0 0

/* flist.f */
common/cosPkg.sv
logic/resetStretch.sv
uart/uartByteRx.sv
csr/commandFramer.sv
csr/ioRegisterBank.sv
logic/cosTop.sv
test/cosTopTb.sv

/* Bender.yml */
package:
  name: cos_uart_ctrl

sources:
  - files:
      - common/cosPkg.sv
      - logic/resetStretch.sv
      - uart/uartByteRx.sv
      - csr/commandFramer.sv
      - csr/ioRegisterBank.sv
      - logic/cosTop.sv
  - target: test
    files:
      - test/cosTopTb.sv
